// File: src/net_hdr_pkg.sv
// Ethernet, IPv4 and UDP wire-format definitions
// Address types, header byte counts and the IPv4 header in two views
`default_nettype none

package net_hdr_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    // Header sizes in bytes, no IP options
    localparam int ETH_HDR_BYTES   = 14;
    localparam int IPV4_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES   = 8;
    localparam int REPLY_HDR_BYTES = ETH_HDR_BYTES + IPV4_HDR_BYTES + UDP_HDR_BYTES;

    // IPv4 header, first field on the wire in the top bits
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [2:0]  flags;
        logic [12:0] frag_off;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
    } ipv4_hdr_t;

    // Field view for building, word view for the checksum
    typedef union packed {
        ipv4_hdr_t        fields;
        logic [9:0][15:0] words;
    } ipv4_hdr_u;

endpackage

`default_nettype wire

// File: src/echo_pkg.sv
// UDP echo responder definitions
// Per-frame reply record and the default local configuration
`default_nettype none

package echo_pkg;

    // Everything the builder needs to answer one request
    typedef struct packed {
        net_hdr_pkg::mac_addr_t peer_mac;
        net_hdr_pkg::ip_addr_t  peer_ip;
        logic [15:0]            peer_port;
        logic [15:0]            local_port;
        logic [15:0]            udp_len;
    } echo_hdr_t;

    localparam int ECHO_HDR_W = $bits(echo_hdr_t);

    localparam net_hdr_pkg::mac_addr_t DEFAULT_LOCAL_MAC = 48'h02_00_00_00_00_00;
    localparam net_hdr_pkg::ip_addr_t  DEFAULT_LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [15:0]            DEFAULT_ECHO_PORT = 16'd1234;
    localparam logic [7:0]             REPLY_TTL         = 8'd64;

endpackage

`default_nettype wire

// File: src/frame_rx_parser.sv
// Receive parser for Ethernet/IPv4/UDP frames
// Filters on local MAC, IP and echo port, forwards payload and queues the reply record
`default_nettype none

module frame_rx_parser #(
    parameter net_hdr_pkg::mac_addr_t LOCAL_MAC = echo_pkg::DEFAULT_LOCAL_MAC,
    parameter net_hdr_pkg::ip_addr_t  LOCAL_IP  = echo_pkg::DEFAULT_LOCAL_IP,
    parameter logic [15:0]            ECHO_PORT = echo_pkg::DEFAULT_ECHO_PORT
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [7:0]        rx_data,
    input  wire logic              rx_valid,
    input  wire logic              rx_last,
    output logic                   pay_wr_en,
    output logic [8:0]             pay_wr_data,
    output logic                   hdr_wr_en,
    output echo_pkg::echo_hdr_t    hdr_wr_data
);

    localparam int IP_OFS  = net_hdr_pkg::ETH_HDR_BYTES;
    localparam int UDP_OFS = IP_OFS + net_hdr_pkg::IPV4_HDR_BYTES;
    localparam int HDR_END = UDP_OFS + net_hdr_pkg::UDP_HDR_BYTES;

    // Byte position in frame, stops at HDR_END during payload
    logic [5:0]             cnt;
    logic                   drop;
    logic                   chk_en;
    logic [7:0]             chk_byte;
    net_hdr_pkg::mac_addr_t src_mac;
    net_hdr_pkg::ip_addr_t  src_ip;
    logic [15:0]            src_port;
    logic [15:0]            udp_len;

    // Expected value for header bytes that take part in filtering
    always_comb begin
        chk_en   = 1'b1;
        chk_byte = 8'h00;
        if (cnt < 6) begin
            chk_byte = LOCAL_MAC[8 * (5 - int'(cnt)) +: 8];
        end else if (cnt == 12) begin
            chk_byte = net_hdr_pkg::ETHERTYPE_IPV4[15:8];
        end else if (cnt == 13) begin
            chk_byte = net_hdr_pkg::ETHERTYPE_IPV4[7:0];
        end else if (cnt == IP_OFS) begin
            chk_byte = {4'd4, 4'd5};
        end else if (cnt == IP_OFS + 9) begin
            chk_byte = net_hdr_pkg::IP_PROTO_UDP;
        end else if (cnt >= IP_OFS + 16 && cnt < IP_OFS + 20) begin
            chk_byte = LOCAL_IP[8 * (IP_OFS + 19 - int'(cnt)) +: 8];
        end else if (cnt == UDP_OFS + 2) begin
            chk_byte = ECHO_PORT[15:8];
        end else if (cnt == UDP_OFS + 3) begin
            chk_byte = ECHO_PORT[7:0];
        end else begin
            chk_en = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= '0;
            drop      <= 1'b0;
            pay_wr_en <= 1'b0;
            hdr_wr_en <= 1'b0;
        end else begin
            pay_wr_en <= 1'b0;
            hdr_wr_en <= 1'b0;
            if (rx_valid) begin
                if (rx_last) begin
                    cnt  <= '0;
                    drop <= 1'b0;
                end else begin
                    if (cnt < HDR_END) begin
                        cnt <= cnt + 6'd1;
                    end
                    if (cnt < HDR_END && chk_en && rx_data != chk_byte) begin
                        drop <= 1'b1;
                    end
                end
                // Runts end inside the header and never reach this branch
                if (cnt == HDR_END && !drop) begin
                    pay_wr_en <= 1'b1;
                    hdr_wr_en <= rx_last;
                end
            end
        end
    end

    // Header capture and payload staging
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            pay_wr_data <= {rx_last, rx_data};
            if (cnt >= 6 && cnt < 12) begin
                src_mac <= {src_mac[39:0], rx_data};
            end
            if (cnt >= IP_OFS + 12 && cnt < IP_OFS + 16) begin
                src_ip <= {src_ip[23:0], rx_data};
            end
            if (cnt >= UDP_OFS && cnt < UDP_OFS + 2) begin
                src_port <= {src_port[7:0], rx_data};
            end
            if (cnt >= UDP_OFS + 4 && cnt < UDP_OFS + 6) begin
                udp_len <= {udp_len[7:0], rx_data};
            end
        end
    end

    assign hdr_wr_data = '{
        peer_mac:   src_mac,
        peer_ip:    src_ip,
        peer_port:  src_port,
        local_port: ECHO_PORT,
        udp_len:    udp_len
    };

endmodule

`default_nettype wire

// File: src/sync_fifo.sv
// Synchronous FIFO with show-ahead read
// Oldest entry is always presented on rd_data
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             wr_en,
    input  wire logic [WIDTH-1:0] wr_data,
    input  wire logic             rd_en,
    output logic      [WIDTH-1:0] rd_data,
    output logic                  not_empty,
    output logic                  full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && not_empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    assign rd_data   = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == (AW + 1)'(DEPTH));

endmodule

`default_nettype wire

// File: src/reply_builder.sv
// Reply frame builder for the UDP echo path
// Serializes the swapped header with a fresh IPv4 checksum, then streams the payload
`default_nettype none

module reply_builder #(
    parameter net_hdr_pkg::mac_addr_t LOCAL_MAC = echo_pkg::DEFAULT_LOCAL_MAC,
    parameter net_hdr_pkg::ip_addr_t  LOCAL_IP  = echo_pkg::DEFAULT_LOCAL_IP
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire echo_pkg::echo_hdr_t hdr_rd_data,
    input  wire logic                hdr_not_empty,
    output logic                     hdr_rd_en,
    input  wire logic [8:0]          pay_rd_data,
    input  wire logic                pay_not_empty,
    output logic                     pay_rd_en,
    output logic [7:0]               tx_data,
    output logic                     tx_valid,
    output logic                     tx_last,
    input  wire logic                tx_ready,
    output logic [7:0]               leds
);

    localparam int HDR_BITS = 8 * (net_hdr_pkg::ETH_HDR_BYTES + net_hdr_pkg::IPV4_HDR_BYTES
                                   + net_hdr_pkg::UDP_HDR_BYTES);

    typedef enum logic [1:0] {
        IDLE,
        CSUM,
        HEADER,
        PAYLOAD
    } state_t;

    state_t                 state;
    echo_pkg::echo_hdr_t    rec;
    net_hdr_pkg::ipv4_hdr_u ip_base;
    net_hdr_pkg::ipv4_hdr_u ip_tx;
    logic [19:0]            sum;
    logic [16:0]            fold1;
    logic [16:0]            fold2;
    logic [HDR_BITS-1:0]    hdr_sr;
    logic [5:0]             beat;
    logic                   first_pay;
    logic                   accept;

    // IPv4 header of the reply with a zero checksum field
    always_comb begin
        ip_base.fields.version   = 4'd4;
        ip_base.fields.ihl       = 4'd5;
        ip_base.fields.dscp      = 6'd0;
        ip_base.fields.ecn       = 2'd0;
        ip_base.fields.total_len = rec.udp_len + 16'(net_hdr_pkg::IPV4_HDR_BYTES);
        ip_base.fields.ident     = 16'd0;
        ip_base.fields.flags     = 3'd0;
        ip_base.fields.frag_off  = 13'd0;
        ip_base.fields.ttl       = echo_pkg::REPLY_TTL;
        ip_base.fields.protocol  = net_hdr_pkg::IP_PROTO_UDP;
        ip_base.fields.checksum  = 16'd0;
        ip_base.fields.src_ip    = LOCAL_IP;
        ip_base.fields.dst_ip    = rec.peer_ip;
    end

    // One's-complement sum, carries folded back twice
    always_comb begin
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + {4'h0, ip_base.words[i]};
        end
        fold1 = {1'b0, sum[15:0]} + {13'd0, sum[19:16]};
        fold2 = {1'b0, fold1[15:0]} + {16'd0, fold1[16]};
        ip_tx = ip_base;
        ip_tx.fields.checksum = ~fold2[15:0];
    end

    assign accept    = tx_valid && tx_ready;
    assign hdr_rd_en = (state == IDLE) && hdr_not_empty;
    assign pay_rd_en = (state == PAYLOAD) && accept;

    assign tx_valid = (state == HEADER) || ((state == PAYLOAD) && pay_not_empty);
    assign tx_data  = (state == HEADER) ? hdr_sr[HDR_BITS-1 -: 8] : pay_rd_data[7:0];
    assign tx_last  = (state == PAYLOAD) && pay_rd_data[8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            beat      <= '0;
            first_pay <= 1'b0;
            leds      <= 8'h00;
        end else begin
            case (state)
                IDLE: begin
                    if (hdr_not_empty) begin
                        state <= CSUM;
                    end
                end
                CSUM: begin
                    beat      <= '0;
                    first_pay <= 1'b1;
                    state     <= HEADER;
                end
                HEADER: begin
                    if (accept) begin
                        beat <= beat + 6'd1;
                        if (beat == 6'(net_hdr_pkg::REPLY_HDR_BYTES - 1)) begin
                            state <= PAYLOAD;
                        end
                    end
                end
                PAYLOAD: begin
                    if (accept) begin
                        // LEDs show the first byte of every reply
                        if (first_pay) begin
                            leds      <= pay_rd_data[7:0];
                            first_pay <= 1'b0;
                        end
                        if (pay_rd_data[8]) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Record capture and header shift register
    always_ff @(posedge clk) begin
        if (hdr_rd_en) begin
            rec <= hdr_rd_data;
        end
        if (state == CSUM) begin
            hdr_sr <= {rec.peer_mac, LOCAL_MAC, net_hdr_pkg::ETHERTYPE_IPV4, ip_tx.words,
                       rec.local_port, rec.peer_port, rec.udp_len, 16'h0000};
        end else if (state == HEADER && accept) begin
            hdr_sr <= {hdr_sr[HDR_BITS-9:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

// File: src/udp_echo_top.sv
// UDP echo responder top level
// Parser feeds payload and reply-record FIFOs, the builder drains them
`default_nettype none

module udp_echo_top #(
    parameter net_hdr_pkg::mac_addr_t LOCAL_MAC     = echo_pkg::DEFAULT_LOCAL_MAC,
    parameter net_hdr_pkg::ip_addr_t  LOCAL_IP      = echo_pkg::DEFAULT_LOCAL_IP,
    parameter logic [15:0]            ECHO_PORT     = echo_pkg::DEFAULT_ECHO_PORT,
    parameter int                     PAYLOAD_DEPTH = 2048,
    parameter int                     HDR_DEPTH     = 16
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [7:0] rx_data,
    input  wire logic       rx_valid,
    input  wire logic       rx_last,
    output logic      [7:0] tx_data,
    output logic            tx_valid,
    output logic            tx_last,
    input  wire logic       tx_ready,
    output logic      [7:0] leds
);

    logic                pay_wr_en;
    logic [8:0]          pay_wr_data;
    logic                pay_rd_en;
    logic [8:0]          pay_rd_data;
    logic                pay_not_empty;
    logic                pay_full;
    logic                hdr_wr_en;
    echo_pkg::echo_hdr_t hdr_wr_data;
    logic                hdr_rd_en;
    echo_pkg::echo_hdr_t hdr_rd_data;
    logic                hdr_not_empty;
    logic                hdr_full;

    frame_rx_parser #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .ECHO_PORT (ECHO_PORT)
    ) parser_i (
        .clk         (clk),
        .rst         (rst),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .rx_last     (rx_last),
        .pay_wr_en   (pay_wr_en),
        .pay_wr_data (pay_wr_data),
        .hdr_wr_en   (hdr_wr_en),
        .hdr_wr_data (hdr_wr_data)
    );

    // Payload bytes with end-of-frame flag in bit 8
    sync_fifo #(
        .WIDTH (9),
        .DEPTH (PAYLOAD_DEPTH)
    ) payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (pay_wr_en),
        .wr_data   (pay_wr_data),
        .rd_en     (pay_rd_en),
        .rd_data   (pay_rd_data),
        .not_empty (pay_not_empty),
        .full      (pay_full)
    );

    sync_fifo #(
        .WIDTH (echo_pkg::ECHO_HDR_W),
        .DEPTH (HDR_DEPTH)
    ) hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (hdr_wr_en),
        .wr_data   (hdr_wr_data),
        .rd_en     (hdr_rd_en),
        .rd_data   (hdr_rd_data),
        .not_empty (hdr_not_empty),
        .full      (hdr_full)
    );

    reply_builder #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP)
    ) builder_i (
        .clk           (clk),
        .rst           (rst),
        .hdr_rd_data   (hdr_rd_data),
        .hdr_not_empty (hdr_not_empty),
        .hdr_rd_en     (hdr_rd_en),
        .pay_rd_data   (pay_rd_data),
        .pay_not_empty (pay_not_empty),
        .pay_rd_en     (pay_rd_en),
        .tx_data       (tx_data),
        .tx_valid      (tx_valid),
        .tx_last       (tx_last),
        .tx_ready      (tx_ready),
        .leds          (leds)
    );

endmodule

`default_nettype wire

// File: verif/udp_echo_assert.sv
// Protocol checks for the UDP echo responder
// Output stall stability, reset values and FIFO write contract
`default_nettype none

module udp_echo_assert (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic [7:0] tx_data,
    input wire logic       tx_valid,
    input wire logic       tx_last,
    input wire logic       tx_ready,
    input wire logic [7:0] leds,
    input wire logic       pay_wr_en,
    input wire logic       pay_full,
    input wire logic       hdr_wr_en,
    input wire logic       hdr_full
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // A stalled beat stays on the bus unchanged
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
    else begin
        $error("output beat changed while stalled");
        fail_count++;
    end

    // Covers the reset cycles and the one after
    reset_quiet: assert property (@(posedge clk) rst |=> !tx_valid && leds == 8'h00)
    else begin
        $error("tx_valid or leds active during or right after reset");
        fail_count++;
    end

    pay_no_overrun: assert property (@(posedge clk) disable iff (rst)
        pay_wr_en |-> !pay_full)
    else begin
        $error("payload FIFO written while full");
        fail_count++;
    end

    hdr_no_overrun: assert property (@(posedge clk) disable iff (rst)
        hdr_wr_en |-> !hdr_full)
    else begin
        $error("header FIFO written while full");
        fail_count++;
    end

endmodule

bind udp_echo_top udp_echo_assert assert_i (
    .clk       (clk),
    .rst       (rst),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_last   (tx_last),
    .tx_ready  (tx_ready),
    .leds      (leds),
    .pay_wr_en (pay_wr_en),
    .pay_full  (pay_full),
    .hdr_wr_en (hdr_wr_en),
    .hdr_full  (hdr_full)
);

`default_nettype wire

// File: verif/udp_echo_tb.sv
// Testbench for the UDP echo responder
// Sends good and filtered frames, checks replies, checksums and LEDs
`default_nettype none

module udp_echo_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam net_hdr_pkg::mac_addr_t LOCAL_MAC = echo_pkg::DEFAULT_LOCAL_MAC;
    localparam net_hdr_pkg::ip_addr_t  LOCAL_IP  = echo_pkg::DEFAULT_LOCAL_IP;
    localparam logic [15:0]            ECHO_PORT = echo_pkg::DEFAULT_ECHO_PORT;
    localparam int DRAIN_TIMEOUT = 20000;

    // Frame kinds
    localparam int GOOD     = 0;
    localparam int BAD_PORT = 1;
    localparam int BAD_TYPE = 2;
    localparam int BAD_IP   = 3;
    localparam int BAD_MAC  = 4;
    localparam int RUNT     = 5;
    localparam int NO_PAY   = 6;

    logic       clk = 1'b0;
    logic       rst;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_last;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_last;
    logic       tx_ready;
    logic [7:0] leds;

    integer       seed = 32'hce9d9508;
    logic         bp_en;
    logic [7:0]   frame_q [$];
    // Expected beat is {skip data, last, data}
    logic [9:0]   exp_q [$];
    logic [7:0]   exp_led_q [$];
    logic [9:0]   exp_e;
    logic [7:0]   exp_led;
    logic         led_pending = 1'b0;
    logic [159:0] ip_bits;
    int           beat_idx = 0;
    int           reply_idx = 0;
    int           data_errors = 0;
    int           timeouts = 0;
    int           assert_fails;

    udp_echo_top #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .ECHO_PORT (ECHO_PORT)
    ) udp_echo_top_i (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_last  (rx_last),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_last  (tx_last),
        .tx_ready (tx_ready),
        .leds     (leds)
    );

    always #20 clk = ~clk;

    // Random stalls on the output when enabled
    always @(posedge clk) begin
        #2;
        tx_ready = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
    end

    // One's-complement sum of the ten header words with end-around carry
    function automatic logic [15:0] ones_sum(input net_hdr_pkg::ipv4_hdr_u hdr);
        logic [31:0] acc;
        acc = 32'd0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + {16'd0, hdr.words[i]};
        end
        while (acc[31:16] != 16'd0) begin
            acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        end
        return acc[15:0];
    endfunction

    task automatic put_frame(input logic [47:0] val, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            frame_q.push_back(val[8 * i +: 8]);
        end
    endtask

    task automatic put_exp(input logic [47:0] val, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            exp_q.push_back({2'b00, val[8 * i +: 8]});
        end
    endtask

    // Builds one request into frame_q, queues the reply for good frames
    task automatic make_frame(input int kind, input int pay_len);
        net_hdr_pkg::mac_addr_t peer_mac;
        net_hdr_pkg::ip_addr_t  peer_ip;
        logic [15:0]            peer_port;
        logic [15:0]            udp_len;
        logic [7:0]             pay [$];
        peer_mac  = {$random(seed), 16'($random(seed))};
        peer_ip   = $random(seed);
        peer_port = 16'($random(seed));
        if (kind == NO_PAY) begin
            pay_len = 0;
        end
        for (int i = 0; i < pay_len; i++) begin
            pay.push_back(8'($random(seed)));
        end
        udp_len = 16'(pay_len + 8);
        frame_q.delete();
        put_frame((kind == BAD_MAC) ? LOCAL_MAC ^ 48'h1 : LOCAL_MAC, 6);
        put_frame(peer_mac, 6);
        put_frame((kind == BAD_TYPE) ? 16'h86dd : net_hdr_pkg::ETHERTYPE_IPV4, 2);
        put_frame(16'h4500, 2);
        put_frame(udp_len + 16'd20, 2);
        put_frame(32'h1c46_4000, 4);
        put_frame({8'd128, net_hdr_pkg::IP_PROTO_UDP, 16'h0000}, 4);
        put_frame(peer_ip, 4);
        put_frame((kind == BAD_IP) ? LOCAL_IP + 32'd1 : LOCAL_IP, 4);
        put_frame(peer_port, 2);
        put_frame((kind == BAD_PORT) ? ECHO_PORT + 16'd1 : ECHO_PORT, 2);
        put_frame({udp_len, 16'h0000}, 4);
        foreach (pay[i]) begin
            frame_q.push_back(pay[i]);
        end
        if (kind == RUNT) begin
            while (frame_q.size() > 30) begin
                void'(frame_q.pop_back());
            end
        end
        if (kind == GOOD) begin
            put_exp(peer_mac, 6);
            put_exp(LOCAL_MAC, 6);
            put_exp(net_hdr_pkg::ETHERTYPE_IPV4, 2);
            put_exp(16'h4500, 2);
            put_exp(udp_len + 16'd20, 2);
            put_exp(32'd0, 4);
            put_exp({echo_pkg::REPLY_TTL, net_hdr_pkg::IP_PROTO_UDP}, 2);
            // Checksum bytes are checked through the header sum
            exp_q.push_back(10'h200);
            exp_q.push_back(10'h200);
            put_exp(LOCAL_IP, 4);
            put_exp(peer_ip, 4);
            put_exp({ECHO_PORT, peer_port}, 4);
            put_exp({udp_len, 16'h0000}, 4);
            foreach (pay[i]) begin
                exp_q.push_back({1'b0, i == pay.size() - 1, pay[i]});
            end
            exp_led_q.push_back(pay[0]);
        end
    endtask

    task automatic send_frame();
        for (int i = 0; i < frame_q.size(); i++) begin
            @(posedge clk);
            #2;
            rx_data  = frame_q[i];
            rx_valid = 1'b1;
            rx_last  = (i == frame_q.size() - 1);
        end
        @(posedge clk);
        #2;
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %s did not finish within %0d cycles, %0d bytes still missing",
                     what, DRAIN_TIMEOUT, exp_q.size());
            timeouts++;
        end
    endtask

    // Output monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (led_pending) begin
                assert (leds == exp_led) else begin
                    $display("[ERROR] %0t reply %0d leds 0x%02h, expected 0x%02h",
                             $time, reply_idx - 1, leds, exp_led);
                    data_errors++;
                end
                led_pending = 1'b0;
            end
            if (tx_valid && tx_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected output byte 0x%02h at %0t while no reply was pending",
                             tx_data, $time);
                    data_errors++;
                end else begin
                    exp_e = exp_q.pop_front();
                    assert (tx_last == exp_e[8] && (exp_e[9] || tx_data == exp_e[7:0])) else begin
                        $display("[ERROR] %0t reply %0d byte %0d got %0b/0x%02h, expected %0b/0x%02h",
                                 $time, reply_idx, beat_idx, tx_last, tx_data, exp_e[8],
                                 exp_e[7:0]);
                        data_errors++;
                    end
                end
                if (beat_idx >= 14 && beat_idx <= 33) begin
                    ip_bits = {ip_bits[151:0], tx_data};
                end
                if (beat_idx == 33) begin
                    assert (ones_sum(ip_bits) == 16'hffff) else begin
                        $display("[ERROR] %0t reply %0d IPv4 header sum 0x%04h, expected 0xffff",
                                 $time, reply_idx, ones_sum(ip_bits));
                        data_errors++;
                    end
                end
                if (tx_last) begin
                    beat_idx = 0;
                    reply_idx++;
                    if (exp_led_q.size() != 0) begin
                        exp_led     = exp_led_q.pop_front();
                        led_pending = 1'b1;
                    end
                end else begin
                    beat_idx++;
                end
            end
        end
    end

    initial begin
        rst      = 1'b1;
        rx_data  = 8'h00;
        rx_valid = 1'b0;
        rx_last  = 1'b0;
        tx_ready = 1'b1;
        bp_en    = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        make_frame(GOOD, 16);
        send_frame();
        for (int kind = BAD_PORT; kind <= NO_PAY; kind++) begin
            make_frame(kind, 12);
            send_frame();
        end
        make_frame(GOOD, 1);
        send_frame();
        wait_drain("replies of the filter sequence");

        // Back-to-back frames under random stalls
        bp_en = 1'b1;
        for (int f = 0; f < 6; f++) begin
            make_frame(GOOD, 1 + ($random(seed) & 63));
            send_frame();
        end
        wait_drain("replies of the back-pressure sequence");
        repeat (4) @(posedge clk);

        assert_fails = udp_echo_top_i.assert_i.fail_count;
        $display("Errors: %0d data, %0d protocol assertion, %0d timeout",
                 data_errors, assert_fails, timeouts);
        if (data_errors == 0 && assert_fails == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
src/net_hdr_pkg.sv
src/echo_pkg.sv
src/frame_rx_parser.sv
src/sync_fifo.sv
src/reply_builder.sv
src/udp_echo_top.sv
verif/udp_echo_assert.sv
verif/udp_echo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the UDP echo testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module udp_echo_tb -Mdir obj_dir -f build.f

status=0
./obj_dir/Vudp_echo_tb +verilator+error+limit+1000 > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG" || [ "$status" -ne 0 ]; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
echo "Simulation passed"
